// ==== design/mshr_macros.svh ====
`ifndef MSHR_MACROS_SVH
`define MSHR_MACROS_SVH

// ----------------------------------------------------------------------
// table geometry
// ----------------------------------------------------------------------
`define MSHR_ENTRY_NUM  8
`define MSHR_IDX_W      3

// ----------------------------------------------------------------------
// payload widths
// ----------------------------------------------------------------------
`define LINE_ADDR_W     26
`define TXNID_W         8

// data RAM command opcodes
`define RAM_OP_FILL     1'b0    // linefill write
`define RAM_OP_READ     1'b1    // read back for requester

`endif

// ==== design/mshr_pkg.sv ====
`default_nettype none

`include "mshr_macros.svh"

package mshr_pkg;

    typedef logic [`MSHR_IDX_W-1:0]     mshr_idx_t;
    typedef logic [`LINE_ADDR_W-1:0]    line_addr_t;
    typedef logic [`TXNID_W-1:0]        txnid_t;
    typedef logic [0:0]                 ram_op_t;
    typedef logic [`MSHR_ENTRY_NUM-1:0] entry_vec_t;     // one bit per entry

    // life of one miss entry
    typedef enum logic [2:0] {
        ENTRY_IDLE      = 3'd0,
        ENTRY_RESERVED  = 3'd1,     // granted, waiting for update
        ENTRY_MISS_REQ  = 3'd2,
        ENTRY_WAIT_DATA = 3'd3,
        ENTRY_FILL_REQ  = 3'd4,
        ENTRY_WAIT_FILL = 3'd5,
        ENTRY_READ_REQ  = 3'd6,
        ENTRY_WAIT_READ = 3'd7
    } entry_state_t;

endpackage

`default_nettype wire

// ==== design/mshr_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_alloc
    import mshr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  entry_vec_t  v_entry_idle,
    input  logic        alloc_rdy,
    output logic        alloc_vld,
    output mshr_idx_t   alloc_idx,
    output entry_vec_t  alloc_grant,
    output logic        mshr_stall
);

    entry_vec_t v_avail;
    logic       free_vld;
    mshr_idx_t  free_idx;

    // entry granted this cycle still looks idle until the next edge
    assign v_avail = v_entry_idle & ~alloc_grant;

    always_comb begin
        free_vld = |v_avail;
        free_idx = '0;
        for (int i = `MSHR_ENTRY_NUM-1; i >= 0; i--) begin
            if (v_avail[i])
                free_idx = mshr_idx_t'(i);     // lowest wins
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_vld <= 1'b0;
            alloc_idx <= '0;
        end else if (!alloc_vld || alloc_rdy) begin  // offer holds under back-pressure
            alloc_vld <= free_vld;
            alloc_idx <= free_idx;
        end
    end

    assign alloc_grant = (alloc_vld && alloc_rdy) ? (entry_vec_t'(1) << alloc_idx) : '0;

    assign mshr_stall  = ~|v_entry_idle;

endmodule

`default_nettype wire

// ==== design/mshr_entry.sv ====
`timescale 1ns/10ps
`default_nettype none

module mshr_entry
    import mshr_pkg::*;
#(
    parameter mshr_idx_t ENTRY_ID = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        alloc_grant,

    input  logic        mshr_update_en,
    input  mshr_idx_t   mshr_update_idx,
    input  line_addr_t  mshr_update_addr,
    input  txnid_t      mshr_update_txnid,

    output logic        ds_req_vld,
    input  logic        ds_req_rdy,

    output logic        fill_vld,
    input  logic        fill_rdy,
    output logic        read_vld,
    input  logic        read_rdy,

    input  logic        linefill_data_done,
    input  mshr_idx_t   linefill_data_done_idx,
    input  logic        linefill_done,
    input  mshr_idx_t   linefill_done_idx,
    input  logic        rd_done,
    input  mshr_idx_t   rd_done_idx,

    output line_addr_t  entry_addr,
    output txnid_t      entry_txnid,
    output logic        entry_idle,
    output logic        release_en
);

    entry_state_t state;
    entry_state_t state_nxt;
    logic         update_hit;
    logic         lf_data_hit;
    logic         lf_done_hit;
    logic         rd_done_hit;

    // done strobes are broadcast with an index
    assign update_hit  = mshr_update_en && (mshr_update_idx == ENTRY_ID)
                         && (state == ENTRY_RESERVED);
    assign lf_data_hit = linefill_data_done && (linefill_data_done_idx == ENTRY_ID);
    assign lf_done_hit = linefill_done && (linefill_done_idx == ENTRY_ID);
    assign rd_done_hit = rd_done && (rd_done_idx == ENTRY_ID);

    always_ff @(posedge clk) begin
        if (update_hit) begin
            entry_addr  <= mshr_update_addr;
            entry_txnid <= mshr_update_txnid;
        end
    end

    // ----------------------------------------------------------------------
    // life-cycle FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ENTRY_IDLE:
                if (alloc_grant)
                    state_nxt = ENTRY_RESERVED;
            ENTRY_RESERVED:
                if (update_hit)
                    state_nxt = ENTRY_MISS_REQ;
            ENTRY_MISS_REQ:
                if (ds_req_rdy)
                    state_nxt = ENTRY_WAIT_DATA;
            ENTRY_WAIT_DATA:
                if (lf_data_hit)
                    state_nxt = ENTRY_FILL_REQ;
            ENTRY_FILL_REQ:
                if (fill_rdy)
                    state_nxt = ENTRY_WAIT_FILL;
            ENTRY_WAIT_FILL:
                if (lf_done_hit)
                    state_nxt = ENTRY_READ_REQ;
            ENTRY_READ_REQ:
                if (read_rdy)
                    state_nxt = ENTRY_WAIT_READ;
            ENTRY_WAIT_READ:
                if (rd_done_hit)
                    state_nxt = ENTRY_IDLE;
            default:
                state_nxt = ENTRY_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ENTRY_IDLE;
            release_en <= 1'b0;
        end else begin
            state      <= state_nxt;
            release_en <= (state == ENTRY_WAIT_READ) && rd_done_hit;   // one-cycle pulse
        end
    end

    assign entry_idle = (state == ENTRY_IDLE);
    assign ds_req_vld = (state == ENTRY_MISS_REQ);
    assign fill_vld   = (state == ENTRY_FILL_REQ);
    assign read_vld   = (state == ENTRY_READ_REQ);

endmodule

`default_nettype wire

// ==== design/rr_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rr_arb #(
    parameter  int N     = 8,
    parameter  int PLD_W = 8,
    localparam int IDX_W = $clog2(N)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [N-1:0]         v_vld,
    output logic [N-1:0]         v_rdy,
    input  logic [N*PLD_W-1:0]   v_pld,
    output logic                 vld,
    input  logic                 rdy,
    output logic [PLD_W-1:0]     pld,
    output logic [IDX_W-1:0]     grant_idx
);

    logic [IDX_W-1:0] ptr;          // highest priority requester
    logic [IDX_W-1:0] hold_idx;
    logic             hold;         // winner stalled by rdy low
    logic [IDX_W-1:0] search_idx;
    logic             found;

    always_comb begin
        int cand;
        found      = 1'b0;
        search_idx = '0;
        for (int k = 0; k < N; k++) begin
            cand = (int'(ptr) + k) % N;
            if (!found && v_vld[cand]) begin
                found      = 1'b1;
                search_idx = IDX_W'(cand);
            end
        end
    end

    // a stalled winner keeps the port so its payload stays put
    assign grant_idx = hold ? hold_idx : search_idx;
    assign vld       = hold || found;
    assign pld       = v_pld[grant_idx*PLD_W +: PLD_W];

    always_comb begin
        v_rdy            = '0;
        v_rdy[grant_idx] = vld && rdy;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            hold     <= 1'b0;
            hold_idx <= '0;
        end else if (vld && rdy) begin
            ptr  <= (grant_idx == IDX_W'(N-1)) ? '0 : grant_idx + 1'b1;
            hold <= 1'b0;
        end else if (vld) begin
            hold     <= 1'b1;
            hold_idx <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== design/ram_port_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mshr_macros.svh"

module ram_port_arb
    import mshr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  entry_vec_t  v_fill_vld,
    output entry_vec_t  v_fill_rdy,
    input  entry_vec_t  v_read_vld,
    output entry_vec_t  v_read_rdy,
    input  line_addr_t  v_addr  [`MSHR_ENTRY_NUM-1:0],
    input  txnid_t      v_txnid [`MSHR_ENTRY_NUM-1:0],

    output logic        ram_cmd_vld,
    output ram_op_t     ram_cmd_op,
    output mshr_idx_t   ram_cmd_idx,
    output line_addr_t  ram_cmd_addr,
    output txnid_t      ram_cmd_txnid,
    input  logic        ram_rdy
);

    localparam int PLD_W = `TXNID_W + `LINE_ADDR_W;

    logic [`MSHR_ENTRY_NUM*PLD_W-1:0] v_pld;
    logic                             fill_vld;
    logic                             fill_rdy;
    logic [PLD_W-1:0]                 fill_pld;
    mshr_idx_t                        fill_idx;
    logic                             read_vld;
    logic                             read_rdy;
    logic [PLD_W-1:0]                 read_pld;
    mshr_idx_t                        read_idx;

    always_comb begin
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            v_pld[i*PLD_W +: PLD_W] = {v_txnid[i], v_addr[i]};
        end
    end

    // ----------------------------------------------------------------------
    // first stage, one round robin per class
    // ----------------------------------------------------------------------
    rr_arb #(.N(`MSHR_ENTRY_NUM), .PLD_W(PLD_W)) u_fill_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .v_vld     (v_fill_vld),
        .v_rdy     (v_fill_rdy),
        .v_pld     (v_pld),
        .vld       (fill_vld),
        .rdy       (fill_rdy),
        .pld       (fill_pld),
        .grant_idx (fill_idx)
    );

    rr_arb #(.N(`MSHR_ENTRY_NUM), .PLD_W(PLD_W)) u_read_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .v_vld     (v_read_vld),
        .v_rdy     (v_read_rdy),
        .v_pld     (v_pld),
        .vld       (read_vld),
        .rdy       (read_rdy),
        .pld       (read_pld),
        .grant_idx (read_idx)
    );

    // ----------------------------------------------------------------------
    // second stage, linefill writes beat reads
    // ----------------------------------------------------------------------
    assign fill_rdy = ram_rdy;
    assign read_rdy = ram_rdy && !fill_vld;    // a new fill preempts a waiting read

    assign ram_cmd_vld = fill_vld || read_vld;
    assign ram_cmd_op  = fill_vld ? `RAM_OP_FILL : `RAM_OP_READ;
    assign ram_cmd_idx = fill_vld ? fill_idx : read_idx;
    assign {ram_cmd_txnid, ram_cmd_addr} = fill_vld ? fill_pld : read_pld;

endmodule

`default_nettype wire

// ==== design/vec_mshr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mshr_macros.svh"

module vec_mshr
    import mshr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    output logic        alloc_vld,          // to tag pipe
    output mshr_idx_t   alloc_idx,
    input  logic        alloc_rdy,
    output logic        mshr_stall,

    input  logic        mshr_update_en,
    input  mshr_idx_t   mshr_update_idx,
    input  line_addr_t  mshr_update_addr,
    input  txnid_t      mshr_update_txnid,

    output logic        ds_req_vld,
    output line_addr_t  ds_req_addr,
    output mshr_idx_t   ds_req_idx,
    input  logic        ds_req_rdy,

    input  logic        linefill_data_done,
    input  mshr_idx_t   linefill_data_done_idx,
    input  logic        linefill_done,
    input  mshr_idx_t   linefill_done_idx,

    output logic        ram_cmd_vld,
    output ram_op_t     ram_cmd_op,
    output mshr_idx_t   ram_cmd_idx,
    output line_addr_t  ram_cmd_addr,
    output txnid_t      ram_cmd_txnid,
    input  logic        ram_rdy,

    input  logic        rd_done,
    input  mshr_idx_t   rd_done_idx,

    output logic        release_vld,
    output mshr_idx_t   release_idx
);

    entry_vec_t v_entry_idle;
    entry_vec_t v_alloc_grant;
    entry_vec_t v_ds_vld;
    entry_vec_t v_ds_rdy;
    entry_vec_t v_fill_vld;
    entry_vec_t v_fill_rdy;
    entry_vec_t v_read_vld;
    entry_vec_t v_read_rdy;
    entry_vec_t v_release;
    line_addr_t v_entry_addr  [`MSHR_ENTRY_NUM-1:0];
    txnid_t     v_entry_txnid [`MSHR_ENTRY_NUM-1:0];
    logic [`MSHR_ENTRY_NUM*`LINE_ADDR_W-1:0] v_ds_pld;

    mshr_alloc u_alloc (
        .clk          (clk),
        .rst_n        (rst_n),
        .v_entry_idle (v_entry_idle),
        .alloc_rdy    (alloc_rdy),
        .alloc_vld    (alloc_vld),
        .alloc_idx    (alloc_idx),
        .alloc_grant  (v_alloc_grant),
        .mshr_stall   (mshr_stall)
    );

    // ----------------------------------------------------------------------
    // entry array
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < `MSHR_ENTRY_NUM; i++) begin : g_entry
        mshr_entry #(.ENTRY_ID(mshr_idx_t'(i))) u_entry (
            .clk                    (clk),
            .rst_n                  (rst_n),
            .alloc_grant            (v_alloc_grant[i]),
            .mshr_update_en         (mshr_update_en),
            .mshr_update_idx        (mshr_update_idx),
            .mshr_update_addr       (mshr_update_addr),
            .mshr_update_txnid      (mshr_update_txnid),
            .ds_req_vld             (v_ds_vld[i]),
            .ds_req_rdy             (v_ds_rdy[i]),
            .fill_vld               (v_fill_vld[i]),
            .fill_rdy               (v_fill_rdy[i]),
            .read_vld               (v_read_vld[i]),
            .read_rdy               (v_read_rdy[i]),
            .linefill_data_done     (linefill_data_done),
            .linefill_data_done_idx (linefill_data_done_idx),
            .linefill_done          (linefill_done),
            .linefill_done_idx      (linefill_done_idx),
            .rd_done                (rd_done),
            .rd_done_idx            (rd_done_idx),
            .entry_addr             (v_entry_addr[i]),
            .entry_txnid            (v_entry_txnid[i]),
            .entry_idle             (v_entry_idle[i]),
            .release_en             (v_release[i])
        );

        assign v_ds_pld[i*`LINE_ADDR_W +: `LINE_ADDR_W] = v_entry_addr[i];
    end

    // miss requests to downstream, entry index doubles as txn id
    rr_arb #(.N(`MSHR_ENTRY_NUM), .PLD_W(`LINE_ADDR_W)) u_ds_req_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .v_vld     (v_ds_vld),
        .v_rdy     (v_ds_rdy),
        .v_pld     (v_ds_pld),
        .vld       (ds_req_vld),
        .rdy       (ds_req_rdy),
        .pld       (ds_req_addr),
        .grant_idx (ds_req_idx)
    );

    ram_port_arb u_ram_port_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .v_fill_vld    (v_fill_vld),
        .v_fill_rdy    (v_fill_rdy),
        .v_read_vld    (v_read_vld),
        .v_read_rdy    (v_read_rdy),
        .v_addr        (v_entry_addr),
        .v_txnid       (v_entry_txnid),
        .ram_cmd_vld   (ram_cmd_vld),
        .ram_cmd_op    (ram_cmd_op),
        .ram_cmd_idx   (ram_cmd_idx),
        .ram_cmd_addr  (ram_cmd_addr),
        .ram_cmd_txnid (ram_cmd_txnid),
        .ram_rdy       (ram_rdy)
    );

    // release is one-hot, rd_done comes one index at a time
    assign release_vld = |v_release;

    always_comb begin
        release_idx = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (v_release[i])
                release_idx = release_idx | mshr_idx_t'(i);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mshr_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mshr_macros.svh"

module mshr_asserts
    import mshr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        alloc_vld,
    input  mshr_idx_t   alloc_idx,
    input  logic        alloc_rdy,
    input  logic        mshr_stall,
    input  entry_vec_t  v_entry_idle,
    input  entry_vec_t  v_release,
    input  mshr_idx_t   release_idx,
    input  logic        ds_req_vld,
    input  line_addr_t  ds_req_addr,
    input  mshr_idx_t   ds_req_idx,
    input  logic        ds_req_rdy,
    input  logic        ram_cmd_vld,
    input  ram_op_t     ram_cmd_op,
    input  mshr_idx_t   ram_cmd_idx,
    input  line_addr_t  ram_cmd_addr,
    input  txnid_t      ram_cmd_txnid,
    input  logic        ram_rdy
);

    int unsigned fail_cnt = 0;

    // ----------------------------------------------------------------------
    // allocation
    // ----------------------------------------------------------------------
    alloc_offer_idle: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_vld |-> v_entry_idle[alloc_idx] && !mshr_stall)
        else begin $error("allocation offers an entry that is not idle"); fail_cnt++; end

    alloc_offer_holds: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_vld && !alloc_rdy |=> alloc_vld && $stable(alloc_idx))
        else begin $error("allocation offer moved under back-pressure"); fail_cnt++; end

    // ----------------------------------------------------------------------
    // request ports under back-pressure
    // ----------------------------------------------------------------------
    ds_req_holds: assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_req_rdy |=> ds_req_vld && $stable(ds_req_idx)
                                      && $stable(ds_req_addr))
        else begin $error("downstream request moved under back-pressure"); fail_cnt++; end

    fill_cmd_holds: assert property (@(posedge clk) disable iff (!rst_n)
        ram_cmd_vld && !ram_rdy && ram_cmd_op == `RAM_OP_FILL
        |=> ram_cmd_vld && $stable(ram_cmd_op) && $stable(ram_cmd_idx)
            && $stable(ram_cmd_addr) && $stable(ram_cmd_txnid))
        else begin $error("fill command moved under back-pressure"); fail_cnt++; end

    // a stalled read may only give way to a fill
    read_cmd_stays: assert property (@(posedge clk) disable iff (!rst_n)
        ram_cmd_vld && !ram_rdy && ram_cmd_op == `RAM_OP_READ
        |=> ram_cmd_vld && (ram_cmd_op == `RAM_OP_FILL
                            || ($stable(ram_cmd_idx) && $stable(ram_cmd_addr)
                                && $stable(ram_cmd_txnid))))
        else begin $error("read command moved under back-pressure"); fail_cnt++; end

    release_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        v_release != '0 |-> v_release[release_idx] && v_entry_idle[release_idx])
        else begin $error("released entry is not idle or index is wrong"); fail_cnt++; end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;      // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== testbench/tb_vec_mshr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mshr_macros.svh"

module tb_vec_mshr
    import mshr_pkg::*;
();

    localparam int N_TESTS         = 4;
    localparam int WATCHDOG_CYCLES = N_TESTS * 400;

    logic         clk;
    logic         rst_n;
    logic         alloc_vld;
    mshr_idx_t    alloc_idx;
    logic         alloc_rdy;
    logic         mshr_stall;
    logic         mshr_update_en;
    mshr_idx_t    mshr_update_idx;
    line_addr_t   mshr_update_addr;
    txnid_t       mshr_update_txnid;
    logic         ds_req_vld;
    line_addr_t   ds_req_addr;
    mshr_idx_t    ds_req_idx;
    logic         ds_req_rdy;
    logic         linefill_data_done;
    mshr_idx_t    linefill_data_done_idx;
    logic         linefill_done;
    mshr_idx_t    linefill_done_idx;
    logic         ram_cmd_vld;
    ram_op_t      ram_cmd_op;
    mshr_idx_t    ram_cmd_idx;
    line_addr_t   ram_cmd_addr;
    txnid_t       ram_cmd_txnid;
    logic         ram_rdy;
    logic         rd_done;
    mshr_idx_t    rd_done_idx;
    logic         release_vld;
    mshr_idx_t    release_idx;

    int           seed = 32'hc815;
    int           cycle;
    int           err_cnt;
    int           n_failed;
    int           n_grants;
    int           n_done;
    int           budget;       // grants the tag pipe may still take
    int           rdy_pct;
    logic         traffic_on;
    entry_state_t stage [`MSHR_ENTRY_NUM];
    int           due [3][`MSHR_ENTRY_NUM];     // data done, fill done, read done
    line_addr_t   upd_addr  [`MSHR_ENTRY_NUM];
    txnid_t       upd_txnid [`MSHR_ENTRY_NUM];
    mshr_idx_t    resv_q [$];
    logic         exp_alloc_vld;
    mshr_idx_t    exp_alloc_idx;
    logic         exp_rel;
    mshr_idx_t    exp_rel_idx;

    tb_clkgen #(.PERIOD(100), .RST_CYCLES(10)) u_clkgen (.clk(clk), .rst_n(rst_n));

    vec_mshr UUT (.*);

    bind vec_mshr mshr_asserts u_asserts (.*);

    function automatic int rand_upto(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // lowest entry whose strobe of kind k is due
    function automatic int due_idx(input int k);
        int found;
        found = -1;
        for (int i = `MSHR_ENTRY_NUM-1; i >= 0; i--) begin
            if (due[k][i] >= 0 && due[k][i] <= cycle)
                found = i;
        end
        return found;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
        err_cnt++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        err_cnt++;
    endtask

    // ----------------------------------------------------------------------
    // tag pipe, downstream agent and RAM models plus checks
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : model
        int         sel;
        entry_vec_t idle;
        entry_vec_t avail;
        logic       fill_pend;
        if (!rst_n) begin
            cycle         = 0;
            exp_alloc_vld = 1'b0;
            exp_alloc_idx = '0;
            exp_rel       = 1'b0;
            for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
                stage[i]  = ENTRY_IDLE;
                due[0][i] = -1;
                due[1][i] = -1;
                due[2][i] = -1;
            end
        end else begin
            cycle++;
            fill_pend = 1'b0;
            for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
                idle[i] = (stage[i] == ENTRY_IDLE);
                if (stage[i] == ENTRY_FILL_REQ)
                    fill_pend = 1'b1;
            end
            assert (alloc_vld == exp_alloc_vld)
                else report_mismatch("alloc_vld", alloc_vld, exp_alloc_vld);
            if (exp_alloc_vld)
                assert (alloc_idx == exp_alloc_idx)
                    else report_mismatch("alloc_idx", alloc_idx, exp_alloc_idx);
            assert (mshr_stall == ~|idle)
                else report_mismatch("mshr_stall", mshr_stall, ~|idle);
            assert (release_vld == exp_rel)
                else report_mismatch("release_vld", release_vld, exp_rel);
            if (exp_rel)
                assert (release_idx == exp_rel_idx)
                    else report_mismatch("release_idx", release_idx, exp_rel_idx);
            if (ds_req_vld && ds_req_rdy) begin
                assert (stage[ds_req_idx] == ENTRY_MISS_REQ)
                    else report_error("downstream request without a pending miss");
                assert (ds_req_addr == upd_addr[ds_req_idx])
                    else report_mismatch("ds_req_addr", ds_req_addr, upd_addr[ds_req_idx]);
            end
            if (ram_cmd_vld && ram_cmd_op == `RAM_OP_READ)
                assert (!fill_pend) else report_error("read command while a fill waits");
            if (ram_cmd_vld && ram_rdy) begin
                if (ram_cmd_op == `RAM_OP_FILL)
                    assert (stage[ram_cmd_idx] == ENTRY_FILL_REQ)
                        else report_error("fill command before linefill data");
                else
                    assert (stage[ram_cmd_idx] == ENTRY_READ_REQ)
                        else report_error("read command before linefill done");
                assert (ram_cmd_addr == upd_addr[ram_cmd_idx])
                    else report_mismatch("ram_cmd_addr", ram_cmd_addr, upd_addr[ram_cmd_idx]);
                assert (ram_cmd_txnid == upd_txnid[ram_cmd_idx])
                    else report_mismatch("ram_cmd_txnid", ram_cmd_txnid,
                                         upd_txnid[ram_cmd_idx]);
            end

            // advance the model by this cycle's events
            avail = idle;
            if (alloc_vld && alloc_rdy) begin
                stage[alloc_idx] = ENTRY_RESERVED;
                avail[alloc_idx] = 1'b0;
                resv_q.push_back(alloc_idx);
                n_grants++;
                budget--;
            end
            if (!alloc_vld || alloc_rdy) begin
                exp_alloc_vld = |avail;
                for (int i = `MSHR_ENTRY_NUM-1; i >= 0; i--) begin
                    if (avail[i])
                        exp_alloc_idx = mshr_idx_t'(i);
                end
            end
            if (mshr_update_en)
                stage[mshr_update_idx] = ENTRY_MISS_REQ;
            if (ds_req_vld && ds_req_rdy) begin
                stage[ds_req_idx]  = ENTRY_WAIT_DATA;
                due[0][ds_req_idx] = cycle + 1 + rand_upto(6);
            end
            if (linefill_data_done)
                stage[linefill_data_done_idx] = ENTRY_FILL_REQ;
            if (ram_cmd_vld && ram_rdy) begin
                sel = (ram_cmd_op == `RAM_OP_FILL) ? 1 : 2;
                stage[ram_cmd_idx]    = (sel == 1) ? ENTRY_WAIT_FILL : ENTRY_WAIT_READ;
                due[sel][ram_cmd_idx] = cycle + 1 + rand_upto(6);
            end
            if (linefill_done)
                stage[linefill_done_idx] = ENTRY_READ_REQ;
            exp_rel     = rd_done;
            exp_rel_idx = rd_done_idx;
            if (rd_done) begin
                stage[rd_done_idx] = ENTRY_IDLE;
                n_done++;
            end

            // drive the next cycle
            alloc_rdy  <= (budget > 0) && (rand_upto(100) < rdy_pct);
            ds_req_rdy <= (rand_upto(100) < rdy_pct);
            ram_rdy    <= (rand_upto(100) < rdy_pct);
            if (traffic_on && resv_q.size() > 0 && rand_upto(2) == 0) begin
                sel            = resv_q.pop_front();
                upd_addr[sel]  = line_addr_t'($random(seed));
                upd_txnid[sel] = txnid_t'($random(seed));
                mshr_update_en    <= 1'b1;
                mshr_update_idx   <= mshr_idx_t'(sel);
                mshr_update_addr  <= upd_addr[sel];
                mshr_update_txnid <= upd_txnid[sel];
            end else begin
                mshr_update_en <= 1'b0;
            end
            sel = due_idx(0);
            linefill_data_done <= (sel >= 0);
            if (sel >= 0) begin
                due[0][sel] = -1;
                linefill_data_done_idx <= mshr_idx_t'(sel);
            end
            sel = due_idx(1);
            linefill_done <= (sel >= 0);
            if (sel >= 0) begin
                due[1][sel] = -1;
                linefill_done_idx <= mshr_idx_t'(sel);
            end
            sel = due_idx(2);
            rd_done <= (sel >= 0);
            if (sel >= 0) begin
                due[2][sel] = -1;
                rd_done_idx <= mshr_idx_t'(sel);
            end
        end
    end

    task automatic finish_test(input int num, input string name, input int err_start);
        if (err_cnt == err_start) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, err_cnt - err_start);
            n_failed++;
        end
    endtask

    task automatic run_traffic(input int grants, input int pct, input int total);
        @(negedge clk);
        traffic_on = 1'b1;
        rdy_pct    = pct;
        budget     = grants;
        while (n_done < total)
            @(negedge clk);
        repeat (2) @(negedge clk);  // last release
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        int e0;
        alloc_rdy = 1'b0;
        mshr_update_en = 1'b0;
        mshr_update_idx = '0;
        mshr_update_addr = '0;
        mshr_update_txnid = '0;
        ds_req_rdy = 1'b0;
        linefill_data_done = 1'b0;
        linefill_data_done_idx = '0;
        linefill_done = 1'b0;
        linefill_done_idx = '0;
        ram_rdy = 1'b0;
        rd_done = 1'b0;
        rd_done_idx = '0;
        err_cnt = 0;
        n_failed = 0;
        n_grants = 0;
        n_done = 0;
        budget = 0;
        rdy_pct = 50;
        traffic_on = 1'b0;

        wait (rst_n === 1'b1);
        e0 = err_cnt;
        assert (!alloc_vld && !ds_req_vld && !ram_cmd_vld && !release_vld)
            else report_error("outputs not low at reset release");
        @(negedge clk);
        assert (!alloc_vld) else report_error("alloc_vld high in first cycle after reset");
        @(negedge clk);
        assert (alloc_vld && alloc_idx == '0)
            else report_error("entry 0 not offered after reset");
        finish_test(1, "reset", e0);

        e0 = err_cnt;
        rdy_pct = 100;
        budget  = `MSHR_ENTRY_NUM;
        while (n_grants < `MSHR_ENTRY_NUM)
            @(negedge clk);
        repeat (2) @(negedge clk);
        assert (mshr_stall && !alloc_vld) else report_error("full table without stall");
        finish_test(2, "fill table", e0);

        e0 = err_cnt;
        run_traffic(16, 50, 24);
        finish_test(3, "miss traffic", e0);

        e0 = err_cnt;
        run_traffic(24, 30, 48);
        finish_test(4, "back-pressure", e0);

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 N_TESTS, n_failed, err_cnt, UUT.u_asserts.fail_cnt);
        if (n_failed == 0 && err_cnt == 0 && UUT.u_asserts.fail_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/mshr_pkg.sv
design/mshr_alloc.sv
design/mshr_entry.sv
design/rr_arb.sv
design/ram_port_arb.sv
design/vec_mshr.sv
testbench/mshr_asserts.sv
testbench/tb_clkgen.sv
testbench/tb_vec_mshr.sv

// ==== Makefile ====
SIM    = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tb_vec_mshr
FLIST  = flist.f
BUILD  = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
